// ==== include/rv_imm.svh ====
`ifndef RV_IMM_SVH
`define RV_IMM_SVH

// sign-extended immediates of the RV32I instruction formats.
// each macro takes a 32-bit instruction word and returns a 32-bit value.

// I-type covers loads, ALU immediates and jalr.
`define RV32_signext_Iimm(inst) {{21{inst[31]}}, inst[30:20]}

// S-type splits the offset around the rs2 field.
`define RV32_signext_Simm(inst) {{21{inst[31]}}, inst[30:25], inst[11:7]}

// B-type offsets are in units of two bytes, so bit 0 is always zero.
`define RV32_signext_Bimm(inst) {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0}

// U-type places the upper 20 bits and zero fills the rest.
`define RV32_signext_Uimm(inst) {inst[31:12], 12'b0}

// J-type is the scrambled jal offset.
`define RV32_signext_Jimm(inst) {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0}

`endif

// ==== source/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

    localparam int XLEN         = 32;
    localparam int ROB_TAG_BITS = 5;

    typedef logic [XLEN-1:0]         data_t;
    typedef logic [ROB_TAG_BITS-1:0] rob_tag_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_SLT  = 4'h5,
        ALU_SLTU = 4'h6,
        ALU_SLL  = 4'h7,
        ALU_SRL  = 4'h8,
        ALU_SRA  = 4'h9
    } alu_func_e;

    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'h0,
        OPA_IS_NPC  = 2'h1,
        OPA_IS_PC   = 2'h2,
        OPA_IS_ZERO = 2'h3
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'h0,
        OPB_IS_I_IMM = 3'h1,
        OPB_IS_S_IMM = 3'h2,
        OPB_IS_B_IMM = 3'h3,
        OPB_IS_U_IMM = 3'h4,
        OPB_IS_J_IMM = 3'h5
    } opb_sel_e;

    // the conditional codes follow the funct3 order of the ISA.
    typedef enum logic [2:0] {
        BR_BEQ  = 3'h0,
        BR_BNE  = 3'h1,
        BR_JAL  = 3'h2,
        BR_JALR = 3'h3,
        BR_BLT  = 3'h4,
        BR_BGE  = 3'h5,
        BR_BLTU = 3'h6,
        BR_BGEU = 3'h7
    } br_func_e;

    typedef enum logic {
        FU_ALU = 1'b0,
        FU_BR  = 1'b1
    } fu_sel_e;

    typedef struct packed {
        data_t     pc;
        data_t     npc;
        data_t     inst;
        opa_sel_e  opa_select;
        opb_sel_e  opb_select;
        alu_func_e alu_func;
        br_func_e  br_func;
        fu_sel_e   fu_sel;
        rob_tag_t  rob_tag;
        logic      pred_taken;
    } decoded_t;

    typedef struct packed {
        decoded_t decoded;
        data_t    rs1_value;
        data_t    rs2_value;
    } issue_packet_t;

    // one completion record, shared by both units and the result bus.
    typedef struct packed {
        data_t    result;
        rob_tag_t rob_tag;
        logic     take_branch;
        data_t    target;
        logic     pred_correct;
    } fu_packet_t;

endpackage

`default_nettype wire

// ==== source/alu.sv ====
`default_nettype none

`include "rv_imm.svh"

module alu
    import rv_exec_pkg::*;
(
    input  wire           clock,
    input  wire           reset,
    input  logic          issue_valid,
    input  issue_packet_t is_pack,
    input  logic          stall,
    output fu_packet_t    fu_pack,
    output logic          data_ready
);

    decoded_t   dec;
    data_t      opa;
    data_t      opb;
    data_t      result;
    logic       accept;
    fu_packet_t out_q;
    fu_packet_t next_out;

    assign dec     = is_pack.decoded;
    assign accept  = issue_valid && (dec.fu_sel == FU_ALU);
    assign fu_pack = out_q;

    always_comb begin
        case (dec.opa_select)
            OPA_IS_RS1:  opa = is_pack.rs1_value;
            OPA_IS_NPC:  opa = dec.npc;
            OPA_IS_PC:   opa = dec.pc;
            OPA_IS_ZERO: opa = '0;
            default:     opa = '0;
        endcase
    end

    always_comb begin
        case (dec.opb_select)
            OPB_IS_RS2:   opb = is_pack.rs2_value;
            OPB_IS_I_IMM: opb = `RV32_signext_Iimm(dec.inst);
            OPB_IS_S_IMM: opb = `RV32_signext_Simm(dec.inst);
            OPB_IS_B_IMM: opb = `RV32_signext_Bimm(dec.inst);
            OPB_IS_U_IMM: opb = `RV32_signext_Uimm(dec.inst);
            OPB_IS_J_IMM: opb = `RV32_signext_Jimm(dec.inst);
            default:      opb = '0;
        endcase
    end

    // shift amounts only look at the low five bits of opb.
    always_comb begin
        case (dec.alu_func)
            ALU_ADD:  result = opa + opb;
            ALU_SUB:  result = opa - opb;
            ALU_AND:  result = opa & opb;
            ALU_OR:   result = opa | opb;
            ALU_XOR:  result = opa ^ opb;
            ALU_SLT:  result = {31'b0, $signed(opa) < $signed(opb)};
            ALU_SLTU: result = {31'b0, opa < opb};
            ALU_SLL:  result = opa << opb[4:0];
            ALU_SRL:  result = opa >> opb[4:0];
            ALU_SRA:  result = $unsigned($signed(opa) >>> opb[4:0]);
            default:  result = '0;
        endcase
    end

    always_comb begin
        next_out              = '0;
        next_out.result       = result;
        next_out.rob_tag      = dec.rob_tag;
    end

    // a stall holds the finished result until the arbiter takes it.
    always_ff @(posedge clock) begin
        if (reset) begin
            data_ready <= 1'b0;
            out_q      <= '0;
        end else if (stall) begin
            data_ready <= data_ready;
            out_q      <= out_q;
        end else if (accept) begin
            data_ready <= 1'b1;
            out_q      <= next_out;
        end else begin
            data_ready <= 1'b0;
            out_q      <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== source/branch_unit.sv ====
`default_nettype none

`include "rv_imm.svh"

module branch_unit
    import rv_exec_pkg::*;
(
    input  wire           clock,
    input  wire           reset,
    input  logic          issue_valid,
    input  issue_packet_t is_pack,
    input  logic          stall,
    output fu_packet_t    fu_pack,
    output logic          data_ready
);

    decoded_t   dec;
    data_t      rs1;
    data_t      rs2;
    logic       taken;
    logic       is_jump;
    data_t      target;
    data_t      jalr_sum;
    logic       accept;
    fu_packet_t out_q;
    fu_packet_t next_out;

    assign dec     = is_pack.decoded;
    assign rs1     = is_pack.rs1_value;
    assign rs2     = is_pack.rs2_value;
    assign accept  = issue_valid && (dec.fu_sel == FU_BR);
    assign is_jump = (dec.br_func == BR_JAL) || (dec.br_func == BR_JALR);
    assign fu_pack = out_q;

    always_comb begin
        case (dec.br_func)
            BR_BEQ:  taken = (rs1 == rs2);
            BR_BNE:  taken = (rs1 != rs2);
            BR_BLT:  taken = ($signed(rs1) < $signed(rs2));
            BR_BGE:  taken = ($signed(rs1) >= $signed(rs2));
            BR_BLTU: taken = (rs1 < rs2);
            BR_BGEU: taken = (rs1 >= rs2);
            BR_JAL:  taken = 1'b1;
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jalr is register relative and drops bit 0 of the sum.
    assign jalr_sum = rs1 + `RV32_signext_Iimm(dec.inst);

    always_comb begin
        case (dec.br_func)
            BR_JALR: target = {jalr_sum[31:1], 1'b0};
            BR_JAL:  target = dec.pc + `RV32_signext_Jimm(dec.inst);
            default: target = dec.pc + `RV32_signext_Bimm(dec.inst);
        endcase
    end

    always_comb begin
        next_out              = '0;
        next_out.result       = is_jump ? dec.npc : '0;
        next_out.rob_tag      = dec.rob_tag;
        next_out.take_branch  = taken;
        next_out.target       = target;
        next_out.pred_correct = (taken == dec.pred_taken);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            data_ready <= 1'b0;
            out_q      <= '0;
        end else if (stall) begin
            data_ready <= data_ready;
            out_q      <= out_q;
        end else if (accept) begin
            data_ready <= 1'b1;
            out_q      <= next_out;
        end else begin
            data_ready <= 1'b0;
            out_q      <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== source/complete_arbiter.sv ====
`default_nettype none

module complete_arbiter
    import rv_exec_pkg::*;
(
    input  wire        clock,
    input  wire        reset,
    input  fu_packet_t alu_pack,
    input  logic       alu_ready,
    input  fu_packet_t br_pack,
    input  logic       br_ready,
    output logic       alu_stall,
    output logic       br_stall,
    output logic       cdb_valid,
    output fu_packet_t cdb_pkt
);

    logic       grant_br;
    logic       grant_alu;
    logic       any_grant;
    fu_packet_t grant_pkt;

    // branch results always win so that a mispredict is seen as early as possible.
    assign grant_br  = br_ready;
    assign grant_alu = alu_ready && !br_ready;
    assign any_grant = grant_br || grant_alu;

    assign alu_stall = alu_ready && br_ready;
    assign br_stall  = 1'b0;

    always_comb begin
        if (grant_br) begin
            grant_pkt = br_pack;
        end else if (grant_alu) begin
            grant_pkt = alu_pack;
        end else begin
            grant_pkt = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= any_grant;
        end
    end

    // the bus payload only means something while cdb_valid is high.
    always_ff @(posedge clock) begin
        cdb_pkt <= grant_pkt;
    end

endmodule

`default_nettype wire

// ==== source/exec_stage.sv ====
`default_nettype none

module exec_stage
    import rv_exec_pkg::*;
(
    input  wire           clock,
    input  wire           reset,
    input  logic          issue_valid,
    input  issue_packet_t issue_pkt,
    output logic          alu_busy,
    output logic          branch_busy,
    output logic          cdb_valid,
    output fu_packet_t    cdb_pkt
);

    fu_packet_t alu_pack;
    fu_packet_t br_pack;
    logic       alu_ready;
    logic       br_ready;
    logic       alu_stall;
    logic       br_stall;

    // a unit that is stalled by the arbiter cannot take a new packet.
    assign alu_busy    = alu_stall;
    assign branch_busy = br_stall;

    alu u_alu (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .is_pack     (issue_pkt),
        .stall       (alu_stall),
        .fu_pack     (alu_pack),
        .data_ready  (alu_ready)
    );

    branch_unit u_branch_unit (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .is_pack     (issue_pkt),
        .stall       (br_stall),
        .fu_pack     (br_pack),
        .data_ready  (br_ready)
    );

    complete_arbiter u_complete_arbiter (
        .clock     (clock),
        .reset     (reset),
        .alu_pack  (alu_pack),
        .alu_ready (alu_ready),
        .br_pack   (br_pack),
        .br_ready  (br_ready),
        .alu_stall (alu_stall),
        .br_stall  (br_stall),
        .cdb_valid (cdb_valid),
        .cdb_pkt   (cdb_pkt)
    );

endmodule

`default_nettype wire

// ==== verification/exec_stage_asserts.sv ====
`default_nettype none

module exec_stage_asserts
    import rv_exec_pkg::*;
(
    input wire        clock,
    input wire        reset,
    input logic       alu_ready,
    input logic       br_ready,
    input logic       alu_stall,
    input fu_packet_t alu_pack,
    input fu_packet_t br_pack,
    input logic       cdb_valid,
    input fu_packet_t cdb_pkt
);
    timeunit 1ns;
    timeprecision 100ps;

    // a ready branch result reaches the bus in the next cycle, whatever the alu holds.
    branch_wins_bus: assert property (@(posedge clock) disable iff (reset)
        br_ready |=> (cdb_valid && (cdb_pkt == $past(br_pack))))
        else $error("branch result missing from the result bus");

    alu_alone_wins_bus: assert property (@(posedge clock) disable iff (reset)
        (alu_ready && !br_ready) |=> (cdb_valid && (cdb_pkt == $past(alu_pack))))
        else $error("alu result missing from the result bus");

    // a held result must not change while the arbiter makes the alu wait.
    stalled_pack_stable: assert property (@(posedge clock) disable iff (reset)
        alu_stall |=> ($stable(alu_pack) && alu_ready))
        else $error("stalled alu result changed");

    idle_after_reset: assert property (@(posedge clock)
        reset |=> (!cdb_valid && !alu_ready && !br_ready))
        else $error("result bus or unit ready flag high right after reset");

endmodule

bind complete_arbiter exec_stage_asserts u_arbiter_asserts (
    .clock     (clock),
    .reset     (reset),
    .alu_ready (alu_ready),
    .br_ready  (br_ready),
    .alu_stall (alu_stall),
    .alu_pack  (alu_pack),
    .br_pack   (br_pack),
    .cdb_valid (cdb_valid),
    .cdb_pkt   (cdb_pkt)
);

`default_nettype wire

// ==== verification/exec_stage_tb.sv ====
`default_nettype none

`include "rv_imm.svh"

module exec_stage_tb
    import rv_exec_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          RESET_CYCLES = 8;
    localparam logic [15:0] LFSR_SEED    = 16'd20030;

    logic          clock;
    logic          reset;
    logic          issue_valid;
    issue_packet_t issue_pkt;
    logic          alu_busy;
    logic          branch_busy;
    logic          cdb_valid;
    fu_packet_t    cdb_pkt;

    issue_packet_t stim_table[$];
    fu_packet_t    expect_table[$];
    int            issue_cycle[$];
    fu_packet_t    expected_pkt;
    logic [15:0]   lfsr_state  = LFSR_SEED;
    int            cycle_count = 0;
    int            cycle_limit = 1000;
    int            error_count = 0;
    int            next_check  = 0;

    exec_stage u_dut (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_pkt   (issue_pkt),
        .alu_busy    (alu_busy),
        .branch_busy (branch_busy),
        .cdb_valid   (cdb_valid),
        .cdb_pkt     (cdb_pkt)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_word(output data_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    function automatic data_t model_alu(input alu_func_e f, input data_t a, input data_t b);
        logic [63:0] ext;
        logic [4:0]  sh;
        sh  = b[4:0];
        ext = {{32{a[31]}}, a} >> sh;
        case (f)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return ext[31:0];
            default:  return '0;
        endcase
    endfunction

    // signed order is unsigned order with the sign bits flipped.
    function automatic logic model_cond(input br_func_e f, input data_t a, input data_t b);
        data_t sa;
        data_t sb;
        sa = a ^ 32'h8000_0000;
        sb = b ^ 32'h8000_0000;
        case (f)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return sa < sb;
            BR_BGE:  return !(sa < sb);
            BR_BLTU: return a < b;
            BR_BGEU: return !(a < b);
            default: return 1'b1;
        endcase
    endfunction

    task automatic add_op(input fu_sel_e fu, input alu_func_e af, input br_func_e bf,
                          input opa_sel_e oa, input opb_sel_e ob,
                          input data_t rs1, input data_t rs2, input logic pred);
        issue_packet_t p;
        fu_packet_t    e;
        data_t         pc;
        data_t         inst;
        data_t         opa;
        data_t         opb;
        random_word(pc);
        random_word(inst);
        pc[1:0] = 2'b00;
        // an even jalr offset keeps bit 0 of the sum set for an odd rs1.
        if (fu == FU_BR && bf == BR_JALR) begin
            inst[20] = 1'b0;
        end
        p = '0;
        p.decoded.pc         = pc;
        p.decoded.npc        = pc + 32'd4;
        p.decoded.inst       = inst;
        p.decoded.opa_select = oa;
        p.decoded.opb_select = ob;
        p.decoded.alu_func   = af;
        p.decoded.br_func    = bf;
        p.decoded.fu_sel     = fu;
        p.decoded.rob_tag    = rob_tag_t'(stim_table.size());
        p.decoded.pred_taken = pred;
        p.rs1_value          = rs1;
        p.rs2_value          = rs2;
        e         = '0;
        e.rob_tag = p.decoded.rob_tag;
        if (fu == FU_ALU) begin
            case (oa)
                OPA_IS_RS1: opa = rs1;
                OPA_IS_NPC: opa = pc + 32'd4;
                OPA_IS_PC:  opa = pc;
                default:    opa = '0;
            endcase
            case (ob)
                OPB_IS_I_IMM: opb = `RV32_signext_Iimm(inst);
                OPB_IS_S_IMM: opb = `RV32_signext_Simm(inst);
                OPB_IS_B_IMM: opb = `RV32_signext_Bimm(inst);
                OPB_IS_U_IMM: opb = `RV32_signext_Uimm(inst);
                OPB_IS_J_IMM: opb = `RV32_signext_Jimm(inst);
                default:      opb = rs2;
            endcase
            e.result = model_alu(af, opa, opb);
        end else begin
            e.take_branch = model_cond(bf, rs1, rs2);
            if (bf == BR_JALR) begin
                e.target = (rs1 + `RV32_signext_Iimm(inst)) & ~32'd1;
                e.result = pc + 32'd4;
            end else if (bf == BR_JAL) begin
                e.target = pc + `RV32_signext_Jimm(inst);
                e.result = pc + 32'd4;
            end else begin
                e.target = pc + `RV32_signext_Bimm(inst);
            end
            e.pred_correct = (e.take_branch == pred);
        end
        stim_table.push_back(p);
        expect_table.push_back(e);
    endtask

    task automatic build_table();
        br_func_e cond_list[6];
        data_t    pair_a[4];
        data_t    pair_b[4];
        data_t    r1;
        data_t    r2;
        cond_list = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
        pair_a    = '{32'd5, 32'd3, 32'hFFFF_FFFB, 32'd7};
        pair_b    = '{32'd5, 32'd7, 32'd3, 32'd3};
        // random rs2 values are almost always above 31, which exercises shift masking.
        for (int f = 0; f < 10; f++) begin
            for (int a = 0; a < 4; a++) begin
                for (int b = 0; b < 6; b++) begin
                    random_word(r1);
                    random_word(r2);
                    add_op(FU_ALU, alu_func_e'(f), BR_BEQ, opa_sel_e'(a), opb_sel_e'(b),
                           r1, r2, 1'b0);
                end
            end
        end
        for (int c = 0; c < 6; c++) begin
            for (int k = 0; k < 4; k++) begin
                for (int pr = 0; pr < 2; pr++) begin
                    add_op(FU_BR, ALU_ADD, cond_list[c], OPA_IS_RS1, OPB_IS_RS2,
                           pair_a[k], pair_b[k], pr[0]);
                end
            end
        end
        for (int pr = 0; pr < 2; pr++) begin
            random_word(r1);
            random_word(r2);
            add_op(FU_BR, ALU_ADD, BR_JAL, OPA_IS_RS1, OPB_IS_RS2, r1, r2, pr[0]);
            add_op(FU_BR, ALU_ADD, BR_JALR, OPA_IS_RS1, OPB_IS_RS2, r1 | 32'd1, r2, pr[0]);
        end
        // a branch directly followed by an alu operation.
        for (int k = 0; k < 4; k++) begin
            random_word(r1);
            random_word(r2);
            add_op(FU_BR, ALU_ADD, BR_BNE, OPA_IS_RS1, OPB_IS_RS2, r1, r2, 1'b1);
            add_op(FU_ALU, ALU_ADD, BR_BEQ, OPA_IS_RS1, OPB_IS_RS2, r1, r2, 1'b0);
        end
        for (int k = 0; k < 40; k++) begin
            random_word(r1);
            random_word(r2);
            add_op(FU_ALU, (k % 3 == 0) ? ALU_ADD : ((k % 3 == 1) ? ALU_SUB : ALU_XOR),
                   BR_BEQ, OPA_IS_RS1, OPB_IS_RS2, r1, r2, 1'b0);
        end
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d results seen",
                     cycle_count, next_check, expect_table.size());
            $display("Result: FAILED");
            $finish;
        end
    end

    // outputs settle well before the falling edge.
    always @(negedge clock) begin
        if (!reset && cdb_valid) begin
            if (next_check >= expect_table.size()) begin
                error_count++;
                $display("an extra result appeared on the result bus at %0t", $time);
            end else begin
                expected_pkt = expect_table[next_check];
                if (cdb_pkt !== expected_pkt) begin
                    error_count++;
                    $display("CHECK FAILED %0t entry %0d: got %h, expected %h",
                             $time, next_check, cdb_pkt, expected_pkt);
                end
                if (cycle_count != issue_cycle[next_check] + 2) begin
                    error_count++;
                    $display("CHECK FAILED %0t entry %0d: result after %0d cycles",
                             $time, next_check, cycle_count - issue_cycle[next_check]);
                end
                next_check++;
            end
        end
    end

    initial begin
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue_pkt   = '0;
        build_table();
        cycle_limit = RESET_CYCLES + 4 * stim_table.size() + 50;
        repeat (RESET_CYCLES) @(posedge clock);
        #2 reset = 1'b0;
        repeat (5) @(posedge clock);
        #2;
        if (cdb_valid || alu_busy || branch_busy) begin
            error_count++;
            $display("CHECK FAILED %0t: outputs not idle after reset", $time);
        end
        foreach (stim_table[i]) begin
            while ((stim_table[i].decoded.fu_sel == FU_ALU) ? alu_busy : branch_busy) begin
                issue_valid = 1'b0;
                @(posedge clock);
                #2;
            end
            issue_valid = 1'b1;
            issue_pkt   = stim_table[i];
            issue_cycle.push_back(cycle_count);
            @(posedge clock);
            #2;
        end
        issue_valid = 1'b0;
        while (next_check < expect_table.size()) begin
            @(posedge clock);
        end
        repeat (5) @(posedge clock);
        $display("checked %0d of %0d results, errors %0d",
                 next_check, expect_table.size(), error_count);
        if (error_count == 0 && next_check == expect_table.size()) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_exec.f ====
+incdir+include
source/rv_exec_pkg.sv
source/alu.sv
source/branch_unit.sv
source/complete_arbiter.sv
source/exec_stage.sv
verification/exec_stage_asserts.sv
verification/exec_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exec_stage_tb
FILELIST  ?= rv_exec.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Result: PASSED

BINARY := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(shell sed -n '/^[^+]/p' $(FILELIST)) include/rv_imm.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BINARY)
	@output="$$(./$(BINARY) 2>&1)"; \
	echo "$$output"; \
	echo "$$output" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
